/* hdl/mult_config.svh */
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// operand and product widths
`define MULT_A_W 18
`define MULT_P_W 36

// a Booth row is two bits wider than an operand so that twice the multiplicand fits
`define MULT_PP_W 20
`define MULT_PP_N 9

// stage register enables, 1 places a register at that point and 0 leaves it combinational
`define MULT_PIPE_DEC  1
`define MULT_PIPE_LVL3 1
`define MULT_PIPE_LVL5 1
`define MULT_PIPE_OUT  1

// cycles from an accepted operand pair to its product
`define MULT_LATENCY (`MULT_PIPE_DEC + `MULT_PIPE_LVL3 + `MULT_PIPE_LVL5 + `MULT_PIPE_OUT)

`endif

/* hdl/mult_pkg.sv */
`include "mult_config.svh"

package mult_pkg;

  // both operands are two's complement
  typedef struct packed {
    logic signed [`MULT_A_W-1:0] mcand;
    logic signed [`MULT_A_W-1:0] mplier;
  } operands_t;

  // row i carries weight 4**i and is already sign-extended to the row width
  // negative rows are only inverted, the missing +1 sits at bit 2i of neg
  typedef struct packed {
    logic [`MULT_PP_N-1:0][`MULT_PP_W-1:0] row;
    logic [`MULT_A_W-1:0]                  neg;
  } pp_rows_t;

  // sum bit k has weight 2**k
  // carry bit k is the majority output at column k, so it still needs one left shift
  typedef struct packed {
    logic [`MULT_P_W-1:0] sum;
    logic [`MULT_P_W-1:0] carry;
  } csa_pair_t;

endpackage

/* hdl/csa_row.sv */
module csa_row #(
  parameter int WIDTH = 36
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic [WIDTH-1:0] c,
  output logic [WIDTH-1:0] sum,
  output logic [WIDTH-1:0] carry
);

  // one full adder per column, no carry ripples between columns
  assign sum   = a ^ b ^ c;
  // the carry stays at its own column, the caller moves it up by one
  assign carry = (a & b) | (a & c) | (b & c);

endmodule

/* hdl/booth_decode.sv */
`include "mult_config.svh"

module booth_decode (
  input  logic                clk,
  input  logic                rstn,
  input  logic                in_valid,
  input  mult_pkg::operands_t in_ops,
  output logic                pp_valid,
  output mult_pkg::pp_rows_t  pp
);
  import mult_pkg::*;

  logic [`MULT_A_W:0]    mplier_ext;
  logic [`MULT_PP_W-1:0] mcand_x1;
  logic [`MULT_PP_W-1:0] mcand_x2;
  pp_rows_t              pp_d;

  // an implicit zero sits below bit 0 of the multiplier
  assign mplier_ext = {in_ops.mplier, 1'b0};
  assign mcand_x1   = {{(`MULT_PP_W-`MULT_A_W){in_ops.mcand[`MULT_A_W-1]}}, in_ops.mcand};
  assign mcand_x2   = {mcand_x1[`MULT_PP_W-2:0], 1'b0};

  always_comb begin
    logic [2:0]            triple;
    logic [`MULT_PP_W-1:0] sel;
    logic                  neg;
    pp_d = '0;
    for (int i = 0; i < `MULT_PP_N; i++) begin
      triple = mplier_ext[2*i +: 3];
      // 111 is a zero digit and must not raise the correction bit
      neg = triple[2] & ~(triple[1] & triple[0]);
      case (triple)
        3'b001, 3'b010, 3'b101, 3'b110: sel = mcand_x1;
        3'b011, 3'b100:                 sel = mcand_x2;
        default:                        sel = '0;
      endcase
      pp_d.row[i]     = neg ? ~sel : sel;
      pp_d.neg[2*i]   = neg;
    end
  end

  generate
    if (`MULT_PIPE_DEC) begin : g_pipe
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          pp_valid <= 1'b0;
          pp       <= '0;
        end else begin
          pp_valid <= in_valid;
          pp       <= pp_d;
        end
      end
    end else begin : g_comb
      assign pp_valid = in_valid;
      assign pp       = pp_d;
    end
  endgenerate

endmodule

/* hdl/wallace_execute.sv */
`include "mult_config.svh"

module wallace_execute (
  input  logic                clk,
  input  logic                rstn,
  input  logic                pp_valid,
  input  mult_pkg::pp_rows_t  pp,
  output logic                cs_valid,
  output mult_pkg::csa_pair_t cs
);
  import mult_pkg::*;

  logic [`MULT_P_W-1:0] lvl0 [`MULT_PP_N+1];
  logic [`MULT_P_W-1:0] lvl1 [7];
  logic [`MULT_P_W-1:0] lvl2 [5];
  logic [`MULT_P_W-1:0] lvl3 [4];
  logic [`MULT_P_W-1:0] lvl3_q [4];
  logic [`MULT_P_W-1:0] lvl4 [3];
  logic [`MULT_P_W-1:0] lvl3_carry;
  logic [`MULT_P_W-1:0] lvl4_carry;
  logic [`MULT_P_W-1:0] lvl5_sum;
  logic [`MULT_P_W-1:0] lvl5_carry;
  logic                 lvl3_valid;
  csa_pair_t            cs_d;

  // place every Booth row at its product weight
  always_comb begin
    for (int i = 0; i < `MULT_PP_N; i++) begin
      lvl0[i] = {{(`MULT_P_W-`MULT_PP_W){pp.row[i][`MULT_PP_W-1]}}, pp.row[i]} << (2*i);
    end
    lvl0[`MULT_PP_N] = {{(`MULT_P_W-`MULT_A_W){1'b0}}, pp.neg};
  end

  // 10 rows to 7
  for (genvar k = 0; k < 3; k++) begin : g_lvl1
    logic [`MULT_P_W-1:0] carry;
    csa_row #(.WIDTH(`MULT_P_W)) u_csa (
      .a    (lvl0[3*k]),
      .b    (lvl0[3*k+1]),
      .c    (lvl0[3*k+2]),
      .sum  (lvl1[2*k]),
      .carry(carry)
    );
    assign lvl1[2*k+1] = {carry[`MULT_P_W-2:0], 1'b0};
  end
  assign lvl1[6] = lvl0[`MULT_PP_N];

  // 7 rows to 5
  for (genvar k = 0; k < 2; k++) begin : g_lvl2
    logic [`MULT_P_W-1:0] carry;
    csa_row #(.WIDTH(`MULT_P_W)) u_csa (
      .a    (lvl1[3*k]),
      .b    (lvl1[3*k+1]),
      .c    (lvl1[3*k+2]),
      .sum  (lvl2[2*k]),
      .carry(carry)
    );
    assign lvl2[2*k+1] = {carry[`MULT_P_W-2:0], 1'b0};
  end
  assign lvl2[4] = lvl1[6];

  // 5 rows to 4
  csa_row #(.WIDTH(`MULT_P_W)) u_csa3 (
    .a    (lvl2[0]),
    .b    (lvl2[1]),
    .c    (lvl2[2]),
    .sum  (lvl3[0]),
    .carry(lvl3_carry)
  );
  assign lvl3[1] = {lvl3_carry[`MULT_P_W-2:0], 1'b0};
  assign lvl3[2] = lvl2[3];
  assign lvl3[3] = lvl2[4];

  generate
    if (`MULT_PIPE_LVL3) begin : g_pipe3
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          lvl3_valid <= 1'b0;
          lvl3_q     <= '{default: '0};
        end else begin
          lvl3_valid <= pp_valid;
          lvl3_q     <= lvl3;
        end
      end
    end else begin : g_comb3
      assign lvl3_valid = pp_valid;
      assign lvl3_q     = lvl3;
    end
  endgenerate

  // 4 rows to 3
  csa_row #(.WIDTH(`MULT_P_W)) u_csa4 (
    .a    (lvl3_q[0]),
    .b    (lvl3_q[1]),
    .c    (lvl3_q[2]),
    .sum  (lvl4[0]),
    .carry(lvl4_carry)
  );
  assign lvl4[1] = {lvl4_carry[`MULT_P_W-2:0], 1'b0};
  assign lvl4[2] = lvl3_q[3];

  // 3 rows to the final pair, the carry leaves unshifted
  csa_row #(.WIDTH(`MULT_P_W)) u_csa5 (
    .a    (lvl4[0]),
    .b    (lvl4[1]),
    .c    (lvl4[2]),
    .sum  (lvl5_sum),
    .carry(lvl5_carry)
  );
  assign cs_d = '{sum: lvl5_sum, carry: lvl5_carry};

  generate
    if (`MULT_PIPE_LVL5) begin : g_pipe5
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          cs_valid <= 1'b0;
          cs       <= '0;
        end else begin
          cs_valid <= lvl3_valid;
          cs       <= cs_d;
        end
      end
    end else begin : g_comb5
      assign cs_valid = lvl3_valid;
      assign cs       = cs_d;
    end
  endgenerate

endmodule

/* hdl/product_result.sv */
`include "mult_config.svh"

module product_result (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        cs_valid,
  input  mult_pkg::csa_pair_t         cs,
  output logic                        out_valid,
  output logic signed [`MULT_P_W-1:0] product
);

  logic [`MULT_P_W-1:0] total;

  // the carry out of the top column is dropped, which gives the product modulo 2**36
  assign total = cs.sum + {cs.carry[`MULT_P_W-2:0], 1'b0};

  generate
    if (`MULT_PIPE_OUT) begin : g_pipe
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          out_valid <= 1'b0;
          product   <= '0;
        end else begin
          out_valid <= cs_valid;
          product   <= total;
        end
      end
    end else begin : g_comb
      assign out_valid = cs_valid;
      assign product   = total;
    end
  endgenerate

endmodule

/* hdl/booth_mult_top.sv */
`include "mult_config.svh"

module booth_mult_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        in_valid,
  input  mult_pkg::operands_t         in_ops,
  output logic                        out_valid,
  output logic signed [`MULT_P_W-1:0] product
);
  import mult_pkg::*;

  logic      pp_valid;
  pp_rows_t  pp;
  logic      cs_valid;
  csa_pair_t cs;

  booth_decode u_decode (
    .clk     (clk),
    .rstn    (rstn),
    .in_valid(in_valid),
    .in_ops  (in_ops),
    .pp_valid(pp_valid),
    .pp      (pp)
  );

  wallace_execute u_execute (
    .clk     (clk),
    .rstn    (rstn),
    .pp_valid(pp_valid),
    .pp      (pp),
    .cs_valid(cs_valid),
    .cs      (cs)
  );

  product_result u_result (
    .clk      (clk),
    .rstn     (rstn),
    .cs_valid (cs_valid),
    .cs       (cs),
    .out_valid(out_valid),
    .product  (product)
  );

endmodule

/* dv/booth_mult_asserts.sv */
`include "mult_config.svh"

module booth_mult_asserts (
  input logic                 clk,
  input logic                 rstn,
  input logic                 in_valid,
  input logic                 out_valid,
  input logic [`MULT_P_W-1:0] product
);

  localparam int LAT = `MULT_LATENCY;

  // every valid register resets, so nothing can come out while rstn is low
  a_reset_quiet: assert property (@(posedge clk) !rstn |-> !out_valid)
    else $error("out_valid high while rstn is low");

  a_valid_follows: assert property (@(posedge clk) disable iff (!rstn)
    in_valid |-> ##LAT out_valid)
    else $error("out_valid missing %0d cycles after in_valid", LAT);

  a_no_spurious: assert property (@(posedge clk) disable iff (!rstn)
    !in_valid |-> ##LAT !out_valid)
    else $error("out_valid high without a matching in_valid");

  a_product_known: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> !$isunknown(product))
    else $error("product has unknown bits while out_valid is high");

endmodule

bind booth_mult_top booth_mult_asserts u_asserts (
  .clk      (clk),
  .rstn     (rstn),
  .in_valid (in_valid),
  .out_valid(out_valid),
  .product  (product)
);

/* dv/booth_mult_tb.sv */
`include "mult_config.svh"

module booth_mult_tb;
  import mult_pkg::*;

  logic                        clk;
  logic                        rstn;
  logic                        in_valid;
  operands_t                   in_ops;
  logic                        out_valid;
  logic signed [`MULT_P_W-1:0] product;

  // expected products in issue order, and the in_valid history for timing checks
  logic signed [`MULT_P_W-1:0] exp_q[$];
  logic                        valid_q[$];
  int                          checks = 0;
  int                          errors = 0;
  int                          tests_run = 0;
  int                          tests_failed = 0;
  int                          test_errors_start = 0;

  booth_mult_top u_dut (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .in_ops   (in_ops),
    .out_valid(out_valid),
    .product  (product)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic signed [`MULT_P_W-1:0] true_product(
    input logic signed [`MULT_A_W-1:0] a,
    input logic signed [`MULT_A_W-1:0] b
  );
    longint full;
    full = longint'(a) * longint'(b);
    return full[`MULT_P_W-1:0];
  endfunction

  // inputs and outputs are both sampled here, before the edge updates any register
  always @(posedge clk) begin
    logic signed [`MULT_P_W-1:0] exp_p;
    logic                        exp_v;
    if (!rstn) begin
      exp_q.delete();
      valid_q.delete();
      checks++;
      assert (out_valid === 1'b0) else begin
        $display("FAILED t=%0t out_valid expected 0 got %b", $time, out_valid);
        errors++;
      end
    end else begin
      if (in_valid) begin
        exp_q.push_back(true_product(in_ops.mcand, in_ops.mplier));
      end
      valid_q.push_back(in_valid);
      if (valid_q.size() > `MULT_LATENCY) begin
        exp_v = valid_q.pop_front();
        checks++;
        assert (out_valid === exp_v) else begin
          $display("FAILED t=%0t out_valid expected %b got %b", $time, exp_v, out_valid);
          errors++;
        end
      end
      if (out_valid) begin
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("out_valid was high at t=%0t with no product outstanding", $time);
          errors++;
        end
        if (exp_q.size() > 0) begin
          exp_p = exp_q.pop_front();
          checks++;
          assert (product === exp_p) else begin
            $display("FAILED t=%0t product expected %0d got %0d", $time, exp_p, product);
            errors++;
          end
        end
      end
    end
  end

  task automatic send_pair(input logic [`MULT_A_W-1:0] a, input logic [`MULT_A_W-1:0] b);
    @(negedge clk);
    in_valid = 1'b1;
    in_ops   = '{mcand: a, mplier: b};
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
    in_ops   = '{mcand: `MULT_A_W'($urandom), mplier: `MULT_A_W'($urandom)};
  endtask

  task automatic begin_test();
    test_errors_start = errors;
  endtask

  // stop driving, wait until every queued product has come out, then report the test
  task automatic finish_test(input string name);
    int n;
    idle_cycle();
    n = 0;
    while (exp_q.size() > 0 && n < `MULT_LATENCY + 16) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("timed out in %s waiting for out_valid, %0d products missing", name,
               exp_q.size());
      $display("Checks failed");
      $finish;
    end else begin
      tests_run++;
      if (errors > test_errors_start) begin
        tests_failed++;
      end
      $display("test %s done with %0d errors", name, errors - test_errors_start);
    end
  endtask

  initial begin
    int                   corner [5];
    logic [`MULT_A_W-1:0] mpliers [10];
    void'($urandom(2076));
    corner  = '{-131072, -1, 0, 1, 131071};
    mpliers = '{18'h2AAAA, 18'h15555, 18'h3FFFF, 18'h1FFFF, 18'h20000,
                18'h0F0F0, 18'h33333, 18'h0CCCC, 18'h38E38, 18'h071C7};
    rstn     = 1'b0;
    in_valid = 1'b0;
    in_ops   = '0;
    repeat (16) @(negedge clk);
    rstn = 1'b1;

    begin_test();
    repeat (300) send_pair(`MULT_A_W'($urandom), `MULT_A_W'($urandom));
    finish_test("random_pairs");

    begin_test();
    foreach (corner[i]) begin
      foreach (corner[j]) begin
        send_pair(`MULT_A_W'(corner[i]), `MULT_A_W'(corner[j]));
      end
    end
    finish_test("corner_operands");

    begin_test();
    repeat (200) begin
      if ($urandom_range(1)) begin
        send_pair(`MULT_A_W'($urandom), `MULT_A_W'($urandom));
      end else begin
        idle_cycle();
      end
    end
    finish_test("gapped_stream");

    begin_test();
    repeat (10) send_pair(`MULT_A_W'($urandom), `MULT_A_W'($urandom));
    rstn     = 1'b0;
    in_valid = 1'b0;
    #1;
    checks++;
    assert (out_valid === 1'b0) else begin
      $display("FAILED t=%0t out_valid expected 0 got %b", $time, out_valid);
      errors++;
    end
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    // any out_valid in these idle cycles finds no product outstanding in the monitor
    repeat (6) idle_cycle();
    send_pair(`MULT_A_W'($urandom), `MULT_A_W'($urandom));
    finish_test("mid_stream_reset");

    begin_test();
    foreach (mpliers[k]) begin
      send_pair(`MULT_A_W'($urandom), mpliers[k]);
      send_pair(`MULT_A_W'($urandom), mpliers[k]);
      send_pair(`MULT_A_W'(-131072), mpliers[k]);
      send_pair(`MULT_A_W'(131071), mpliers[k]);
    end
    finish_test("booth_digits");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/mult_pkg.sv
hdl/csa_row.sv
hdl/booth_decode.sv
hdl/wallace_execute.sv
hdl/product_result.sv
hdl/booth_mult_top.sv
dv/booth_mult_asserts.sv
dv/booth_mult_tb.sv

/* Bender.yml */
package:
  name: booth_mult

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mult_pkg.sv
      - hdl/csa_row.sv
      - hdl/booth_decode.sv
      - hdl/wallace_execute.sv
      - hdl/product_result.sv
      - hdl/booth_mult_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/booth_mult_asserts.sv
      - dv/booth_mult_tb.sv
